//--- logic/core_macros.svh
// core width and depth macros
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data word, also the instruction width
`define DATA_W 32

`define REG_ADDR_W 5 // register index

// instruction address and memory sizes
`define PC_W 8
`define IMEM_DEPTH 256
`define DMEM_DEPTH 64 // words

// board outputs
`define LED_W 27
`define SEL_W 3

`endif

//--- logic/isa_pkg.sv
// instruction set encodings
`include "core_macros.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        op_r_type = 6'h00,
        op_addi   = 6'h08,
        op_lw     = 6'h23,
        op_sw     = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    function automatic logic [5:0] opcode_of(input logic [`DATA_W-1:0] instr);
        return instr[31:26];
    endfunction

    function automatic logic [5:0] funct_of(input logic [`DATA_W-1:0] instr);
        return instr[5:0];
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] rs_of(input logic [`DATA_W-1:0] instr);
        return instr[25:21];
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] rt_of(input logic [`DATA_W-1:0] instr);
        return instr[20:16];
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] rd_of(input logic [`DATA_W-1:0] instr);
        return instr[15:11];
    endfunction

    // immediate is always sign-extended
    function automatic logic [`DATA_W-1:0] imm_of(input logic [`DATA_W-1:0] instr);
        return {{(`DATA_W - 16){instr[15]}}, instr[15:0]};
    endfunction

endpackage

//--- logic/pipe_pkg.sv
// pipeline control and stage registers
`include "core_macros.svh"

package pipe_pkg;

    typedef struct packed {
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        logic             alu_src_imm; // operand b from immediate
        isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    // control of an instruction that changes nothing
    localparam ctrl_t CTRL_NOP = '{
        reg_write:   1'b0,
        mem_read:    1'b0,
        mem_write:   1'b0,
        alu_src_imm: 1'b0,
        alu_op:      isa_pkg::alu_add
    };

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`DATA_W-1:0]      op_a;   // rs after forwarding
        logic [`DATA_W-1:0]      op_b;   // rt after forwarding
        logic [`DATA_W-1:0]      imm;
        logic [`REG_ADDR_W-1:0]  dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`DATA_W-1:0]      alu_result;
        logic [`DATA_W-1:0]      store_data;
        logic [`REG_ADDR_W-1:0]  dest;
    } ex_mem_t;

endpackage

//--- logic/hazard_if.sv
// producer info back to decode
`timescale 1ns/100ps
`include "core_macros.svh"

interface hazard_if;

    logic [`REG_ADDR_W-1:0] ex_dest;
    logic                   ex_writes;   // reg_write with nonzero dest
    logic                   ex_is_load;

    logic [`REG_ADDR_W-1:0] mem_dest;
    logic                   mem_writes;
    logic                   mem_is_load;
    logic [`DATA_W-1:0]     mem_result;  // forwarded alu result

    modport ex_src (output ex_dest, ex_writes, ex_is_load);

    modport mem_src (output mem_dest, mem_writes, mem_is_load, mem_result);

    modport dec_sink (
        input ex_dest, ex_writes, ex_is_load,
        input mem_dest, mem_writes, mem_is_load, mem_result
    );

endinterface

//--- logic/fetch_stage.sv
// fetch stage
`timescale 1ns/100ps
`include "core_macros.svh"

module fetch_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                load,
    input  logic [`PC_W-1:0]    pc_val,
    input  logic                stall,
    input  logic                imem_we,
    input  logic [`PC_W-1:0]    imem_addr,
    input  logic [`DATA_W-1:0]  imem_data,
    output logic [`PC_W-1:0]    pc,
    output logic [`DATA_W-1:0]  instr
);

    localparam logic [`PC_W-1:0] PC_LAST = `PC_W'(`IMEM_DEPTH - 1);

    logic [`DATA_W-1:0] imem [`IMEM_DEPTH];

    always_ff @(posedge SYS_clk)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_data; // program load port
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (load)
            pc <= pc_val;          // user load wins
        else if (stall || pc == PC_LAST)
            pc <= pc;              // hold, end of program stops here
        else
            pc <= pc + 1'b1;
    end

    // no-ops go down the pipe while a program is being written
    assign instr = load ? '0 : imem[pc];

endmodule

//--- logic/decode_stage.sv
// decode stage and register file
`timescale 1ns/100ps
`include "core_macros.svh"

module decode_stage (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic [`DATA_W-1:0]      instr_in,
    input  logic                    wb_en,
    input  logic [`REG_ADDR_W-1:0]  wb_reg,
    input  logic [`DATA_W-1:0]      wb_data,
    input  logic [`REG_ADDR_W-1:0]  dbg_reg_addr,
    hazard_if.dec_sink              hz,
    output logic                    stall,
    output pipe_pkg::id_ex_t        id_ex,
    output logic                    bubble,
    output logic [`DATA_W-1:0]      rs_value,
    output logic [`DATA_W-1:0]      dbg_reg_data
);

    localparam int RF_DEPTH = 1 << `REG_ADDR_W;

    logic [`DATA_W-1:0]     ifid_instr;
    logic [`DATA_W-1:0]     regs [RF_DEPTH];
    pipe_pkg::ctrl_t        ctrl;
    logic                   reads_rs, reads_rt;
    logic [`REG_ADDR_W-1:0] rs, rt, dest;
    logic [`DATA_W-1:0]     rs_rf, rt_rf, rt_value;
    logic                   ex_hit, mem_hit;

    function automatic logic [`DATA_W-1:0] rf_read(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb_en && wb_reg == addr)
            return wb_data; // write-through from writeback
        return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ifid_instr <= '0;      // all-zero word decodes as a no-op
        else if (!stall)
            ifid_instr <= instr_in;
    end

    assign rs = isa_pkg::rs_of(ifid_instr);
    assign rt = isa_pkg::rt_of(ifid_instr);

    always_comb
    begin
        ctrl     = pipe_pkg::CTRL_NOP;
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        dest     = rt;
        case (isa_pkg::opcode_of(ifid_instr))
            isa_pkg::op_r_type:
            begin
                dest           = isa_pkg::rd_of(ifid_instr);
                ctrl.reg_write = 1'b1;
                case (isa_pkg::funct_of(ifid_instr))
                    isa_pkg::fn_add: ctrl.alu_op = isa_pkg::alu_add;
                    isa_pkg::fn_sub: ctrl.alu_op = isa_pkg::alu_sub;
                    isa_pkg::fn_and: ctrl.alu_op = isa_pkg::alu_and;
                    isa_pkg::fn_or:  ctrl.alu_op = isa_pkg::alu_or;
                    isa_pkg::fn_slt: ctrl.alu_op = isa_pkg::alu_slt;
                    default:         ctrl.reg_write = 1'b0; // unknown funct
                endcase
                reads_rs = ctrl.reg_write;
                reads_rt = ctrl.reg_write;
            end
            isa_pkg::op_addi:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                reads_rs         = 1'b1;
            end
            isa_pkg::op_lw:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                reads_rs         = 1'b1;
            end
            isa_pkg::op_sw:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                reads_rs         = 1'b1;
                reads_rt         = 1'b1; // store data
            end
            default: ;
        endcase
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < RF_DEPTH; i++)
                regs[i] <= '0;
        end
        else if (wb_en && wb_reg != '0)
            regs[wb_reg] <= wb_data;
    end

    always_comb
    begin
        rs_rf        = rf_read(rs);
        rt_rf        = rf_read(rt);
        dbg_reg_data = rf_read(dbg_reg_addr);
    end

    // only a non-load in memory has its value ready
    assign rs_value = (hz.mem_writes && !hz.mem_is_load && hz.mem_dest == rs) ?
                      hz.mem_result : rs_rf;
    assign rt_value = (hz.mem_writes && !hz.mem_is_load && hz.mem_dest == rt) ?
                      hz.mem_result : rt_rf;

    assign ex_hit  = hz.ex_writes &&
                     ((reads_rs && hz.ex_dest == rs) || (reads_rt && hz.ex_dest == rt));
    assign mem_hit = hz.mem_writes && hz.mem_is_load &&
                     ((reads_rs && hz.mem_dest == rs) || (reads_rt && hz.mem_dest == rt));
    assign stall   = ex_hit || mem_hit;
    assign bubble  = stall;

    always_comb
    begin
        id_ex.ctrl = ctrl;
        id_ex.op_a = rs_value;
        id_ex.op_b = rt_value;
        id_ex.imm  = isa_pkg::imm_of(ifid_instr);
        id_ex.dest = dest;
    end

endmodule

//--- logic/execute_stage.sv
// execute stage with ALU
`timescale 1ns/100ps
`include "core_macros.svh"

module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  pipe_pkg::id_ex_t    id_ex,
    input  logic                bubble,
    hazard_if.ex_src            hz,
    output pipe_pkg::ex_mem_t   ex_mem,
    output logic [`DATA_W-1:0]  alu_result
);

    pipe_pkg::id_ex_t   idex_q;
    logic [`DATA_W-1:0] op_b;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            idex_q <= '0;
        else if (bubble)
            idex_q <= '0;      // stall inserts a bubble
        else
            idex_q <= id_ex;
    end

    assign op_b = idex_q.ctrl.alu_src_imm ? idex_q.imm : idex_q.op_b;

    always_comb
    begin
        case (idex_q.ctrl.alu_op)
            isa_pkg::alu_add: alu_result = idex_q.op_a + op_b; // wraps
            isa_pkg::alu_sub: alu_result = idex_q.op_a - op_b;
            isa_pkg::alu_and: alu_result = idex_q.op_a & op_b;
            isa_pkg::alu_or:  alu_result = idex_q.op_a | op_b;
            isa_pkg::alu_slt: alu_result = ($signed(idex_q.op_a) < $signed(op_b)) ?
                                           `DATA_W'(1) : '0;
            default:          alu_result = '0;
        endcase
    end

    always_comb
    begin
        ex_mem.ctrl       = idex_q.ctrl;
        ex_mem.alu_result = alu_result;
        ex_mem.store_data = idex_q.op_b;
        ex_mem.dest       = idex_q.dest;
    end

    // producer info for the decode hazard check
    assign hz.ex_dest    = idex_q.dest;
    assign hz.ex_writes  = idex_q.ctrl.reg_write && idex_q.dest != '0;
    assign hz.ex_is_load = idex_q.ctrl.mem_read;

endmodule

//--- logic/mem_wb_stage.sv
// memory and writeback stages
`timescale 1ns/100ps
`include "core_macros.svh"

module mem_wb_stage (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  pipe_pkg::ex_mem_t       ex_mem,
    hazard_if.mem_src               hz,
    output logic                    wb_en,
    output logic [`REG_ADDR_W-1:0]  wb_reg,
    output logic [`DATA_W-1:0]      wb_data
);

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    pipe_pkg::ex_mem_t      exmem_q;
    logic [`DATA_W-1:0]     dmem [`DMEM_DEPTH];
    logic [DMEM_AW-1:0]     dmem_idx;
    logic [`DATA_W-1:0]     load_data;
    logic                   mw_load;
    logic [`DATA_W-1:0]     mw_alu, mw_mem;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            exmem_q <= '0;
        else
            exmem_q <= ex_mem;
    end

    // word index, byte offset bits dropped
    assign dmem_idx  = exmem_q.alu_result[DMEM_AW+1:2];
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end
        else if (exmem_q.ctrl.mem_write)
            dmem[dmem_idx] <= exmem_q.store_data;
    end

    // MEM/WB control
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            wb_en   <= 1'b0;
            mw_load <= 1'b0;
        end
        else
        begin
            wb_en   <= exmem_q.ctrl.reg_write;
            mw_load <= exmem_q.ctrl.mem_read;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_reg <= exmem_q.dest;
        mw_alu <= exmem_q.alu_result;
        mw_mem <= load_data;
    end

    assign wb_data = mw_load ? mw_mem : mw_alu;

    assign hz.mem_dest    = exmem_q.dest;
    assign hz.mem_writes  = exmem_q.ctrl.reg_write && exmem_q.dest != '0;
    assign hz.mem_is_load = exmem_q.ctrl.mem_read;
    assign hz.mem_result  = exmem_q.alu_result; // forward path into decode

endmodule

//--- logic/pipe5_core.sv
// five-stage pipeline core
`timescale 1ns/100ps
`include "core_macros.svh"

module pipe5_core (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic                    load,
    input  logic [`PC_W-1:0]        pc_val,
    input  logic [`SEL_W-1:0]       output_sel,
    input  logic                    imem_we,
    input  logic [`PC_W-1:0]        imem_addr,
    input  logic [`DATA_W-1:0]      imem_data,
    input  logic [`REG_ADDR_W-1:0]  dbg_reg_addr,
    output logic [`LED_W-1:0]       leds,
    output logic [`DATA_W-1:0]      dbg_reg_data
);

    logic [`PC_W-1:0]       pc;
    logic [`DATA_W-1:0]     instr;
    logic                   stall;
    logic                   bubble;
    pipe_pkg::id_ex_t       id_ex;
    pipe_pkg::ex_mem_t      ex_mem;
    logic [`DATA_W-1:0]     rs_value;
    logic [`DATA_W-1:0]     alu_result;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_reg;
    logic [`DATA_W-1:0]     wb_data;

    hazard_if hz ();

    fetch_stage u_fetch (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load      (load),
        .pc_val    (pc_val),
        .stall     (stall),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .pc        (pc),
        .instr     (instr)
    );

    decode_stage u_decode (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_in     (instr),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .dbg_reg_addr (dbg_reg_addr),
        .hz           (hz),
        .stall        (stall),
        .id_ex        (id_ex),
        .bubble       (bubble),
        .rs_value     (rs_value),
        .dbg_reg_data (dbg_reg_data)
    );

    execute_stage u_execute (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .id_ex      (id_ex),
        .bubble     (bubble),
        .hz         (hz),
        .ex_mem     (ex_mem),
        .alu_result (alu_result)
    );

    mem_wb_stage u_mem_wb (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .hz        (hz),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    always_comb
    begin
        case (output_sel)
            `SEL_W'd0: leds = instr[`LED_W-1:0];
            `SEL_W'd1: leds = rs_value[`LED_W-1:0];
            `SEL_W'd2: leds = alu_result[`LED_W-1:0];
            `SEL_W'd3: leds = `LED_W'(pc);   // zero-extended
            default:   leds = '0;
        endcase
        if (SYS_reset)
            leds = '0;                       // dark during reset
    end

endmodule

//--- sim/pipe5_checker.sv
// reference model and output checks
`timescale 1ns/100ps
`include "core_macros.svh"

module pipe5_checker (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic                    load,
    input  logic [`PC_W-1:0]        pc_val,
    input  logic [`SEL_W-1:0]       output_sel,
    input  logic                    imem_we,
    input  logic [`PC_W-1:0]        imem_addr,
    input  logic [`DATA_W-1:0]      imem_data,
    input  logic [`REG_ADDR_W-1:0]  dbg_reg_addr,
    input  logic [`LED_W-1:0]       leds,
    input  logic [`DATA_W-1:0]      dbg_reg_data,
    input  logic                    reg_check,   // debug read valid this cycle
    output int                      err_count,
    output int                      check_count
);

    localparam int LAST = `IMEM_DEPTH - 1;

    logic [`DATA_W-1:0] m_imem [`IMEM_DEPTH];
    logic [`DATA_W-1:0] m_regs [1 << `REG_ADDR_W];
    logic [`DATA_W-1:0] m_dmem [`DMEM_DEPTH];
    logic               load_q;
    logic               prev_load;
    logic [`PC_W-1:0]   prev_pc_val;
    logic               run_valid;     // previous sample was a running pc
    logic [`LED_W-1:0]  run_pc;
    logic [`LED_W-1:0]  last_pc;
    int                 errs = 0;
    int                 checks = 0;

    assign err_count   = errs;
    assign check_count = checks;

    task automatic compare(input string name, input logic [`DATA_W-1:0] expected, got);
        checks++;
        if (got !== expected)
        begin
            errs++;
            $display("error %s: expected %h, got %h at %0t", name, expected, got, $time);
        end
    endtask

    task automatic write_reg(input logic [4:0] r, input logic [31:0] value);
        if (r != 5'd0)
            m_regs[r] = value;   // register 0 stays zero
    endtask

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % `DMEM_DEPTH);
    endfunction

    // one pass over the whole instruction memory
    task automatic run_model();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  rt;
        logic [4:0]  rd;
        for (int p = 0; p < `IMEM_DEPTH; p++)
        begin
            ins = m_imem[p];
            a   = m_regs[ins[25:21]];
            b   = m_regs[ins[20:16]];
            rt  = ins[20:16];
            rd  = ins[15:11];
            imm = {{16{ins[15]}}, ins[15:0]};
            case (ins[31:26])
                6'h00:
                    case (ins[5:0])
                        6'h20: write_reg(rd, a + b);
                        6'h22: write_reg(rd, a - b);
                        6'h24: write_reg(rd, a & b);
                        6'h25: write_reg(rd, a | b);
                        6'h2A: write_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                6'h08: write_reg(rt, a + imm);
                6'h23: write_reg(rt, m_dmem[word_index(a + imm)]);
                6'h2B: m_dmem[word_index(a + imm)] = b;
                default: ;     // unknown opcode is a no-op
            endcase
        end
    endtask

    // with the pc stopped every stage holds the addi no-op from the last address
    task automatic check_end_leds();
        logic [`DATA_W-1:0] ins;
        logic [`DATA_W-1:0] rs_val;
        logic [`DATA_W-1:0] alu_sum;
        ins     = m_imem[LAST];
        rs_val  = m_regs[ins[25:21]];
        alu_sum = rs_val + {{16{ins[15]}}, ins[15:0]};
        case (output_sel)
            `SEL_W'd0: compare("leds", `DATA_W'(ins[`LED_W-1:0]), `DATA_W'(leds));
            `SEL_W'd1: compare("leds", `DATA_W'(rs_val[`LED_W-1:0]), `DATA_W'(leds));
            `SEL_W'd2: compare("leds", `DATA_W'(alu_sum[`LED_W-1:0]), `DATA_W'(leds));
            `SEL_W'd3: ;
            default:   compare("leds", '0, `DATA_W'(leds));
        endcase
    endtask

    always @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            foreach (m_regs[i])
                m_regs[i] = '0;
            foreach (m_dmem[i])
                m_dmem[i] = '0;
            load_q = 1'b0;
        end
        else
        begin
            if (imem_we)
                m_imem[imem_addr] = imem_data;
            if (load_q && !load)
                run_model();     // program starts here
            load_q = load;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            compare("leds", '0, `DATA_W'(leds));
            prev_load = 1'b0;
            run_valid = 1'b0;
            last_pc   = '0;
        end
        else
        begin
            if (prev_load && output_sel == `SEL_W'd3)
                compare("leds", `DATA_W'(prev_pc_val), `DATA_W'(leds));
            if (!load && output_sel == `SEL_W'd3)
            begin
                checks++;
                if (run_valid && leds < run_pc)
                begin
                    errs++;
                    $display("program counter went back from %0d to %0d at %0t",
                             run_pc, leds, $time);
                end
                run_valid = 1'b1;
                run_pc    = leds;
            end
            else
                run_valid = 1'b0;
            if (output_sel == `SEL_W'd3)
                last_pc = leds;
            if (!load && last_pc == `LED_W'(LAST))
                check_end_leds();
            if (reg_check)
                compare($sformatf("dbg_reg_data[r%0d]", dbg_reg_addr),
                        m_regs[dbg_reg_addr], dbg_reg_data);
            prev_load   = load;
            prev_pc_val = pc_val;
        end
    end

endmodule

//--- sim/pipe5_assert.sv
// bound pipeline assertions
`timescale 1ns/100ps
`include "core_macros.svh"

module pipe5_assert (
    input logic                    SYS_clk,
    input logic                    SYS_reset,
    input logic                    load,
    input logic                    stall,
    input logic [`PC_W-1:0]        pc,
    input logic [`LED_W-1:0]       leds,
    input logic [`REG_ADDR_W-1:0]  dbg_reg_addr,
    input logic [`DATA_W-1:0]      dbg_reg_data
);

    int fail_count = 0;   // read by the testbench at the end

    // user load overrides the stall
    pc_held_on_stall: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset)
        (stall && !load) |=> $stable(pc)
    ) else
    begin
        fail_count++;
        $error("stall did not hold the program counter");
    end

    leds_dark_in_reset: assert property (
        @(posedge SYS_clk) SYS_reset |-> (leds == '0)
    ) else
    begin
        fail_count++;
        $error("leds not zero during reset");
    end

    reg0_reads_zero: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset)
        (dbg_reg_addr == '0) |-> (dbg_reg_data == '0)
    ) else
    begin
        fail_count++;
        $error("debug read of register 0 is not zero");
    end

endmodule

bind pipe5_core pipe5_assert u_assert (
    .SYS_clk      (SYS_clk),
    .SYS_reset    (SYS_reset),
    .load         (load),
    .stall        (stall),
    .pc           (pc),
    .leds         (leds),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data)
);

//--- sim/pipe5_tb.sv
// pipeline core testbench
`timescale 1ns/100ps
`include "core_macros.svh"

module pipe5_tb;

    localparam int NUM_TESTS   = 5;
    localparam int RUN_TIMEOUT = 1500;   // cycles from release to the last address
    localparam logic [`LED_W-1:0] PC_END = `LED_W'(`IMEM_DEPTH - 1);

    logic                   SYS_clk;
    logic                   SYS_reset;
    logic                   load;
    logic [`PC_W-1:0]       pc_val;
    logic [`SEL_W-1:0]      output_sel;
    logic                   imem_we;
    logic [`PC_W-1:0]       imem_addr;
    logic [`DATA_W-1:0]     imem_data;
    logic [`REG_ADDR_W-1:0] dbg_reg_addr;
    logic [`LED_W-1:0]      leds;
    logic [`DATA_W-1:0]     dbg_reg_data;
    logic                   reg_check;
    logic                   timed_out;
    int                     err_count;
    int                     check_count;
    int                     tests_run;
    int                     tests_failed;
    int                     assert_fails;
    logic [`DATA_W-1:0]     prog [`IMEM_DEPTH];

    pipe5_core u_pipe5_core (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .load         (load),
        .pc_val       (pc_val),
        .output_sel   (output_sel),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dbg_reg_addr (dbg_reg_addr),
        .leds         (leds),
        .dbg_reg_data (dbg_reg_data)
    );

    pipe5_checker u_checker (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .load         (load),
        .pc_val       (pc_val),
        .output_sel   (output_sel),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dbg_reg_addr (dbg_reg_addr),
        .leds         (leds),
        .dbg_reg_data (dbg_reg_data),
        .reg_check    (reg_check),
        .err_count    (err_count),
        .check_count  (check_count)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #2 SYS_clk = ~SYS_clk;
    end

    function automatic logic [31:0] encode_r(input logic [5:0] funct,
                                             input logic [4:0] rd, rs, rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rt, rs,
                                             input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // mostly r1..r7, now and then r0
    function automatic logic [`REG_ADDR_W-1:0] random_reg();
        if ($urandom % 8 == 0)
            return '0;
        return `REG_ADDR_W'(1 + $urandom % 7);
    endfunction

    function automatic int kind_of(input int num);
        case (num)
            0:       return 0;
            3:       return 2;
            default: return 1;
        endcase
    endfunction

    function automatic string test_name(input int kind);
        case (kind)
            0:       return "alu chain";
            1:       return "load store mix";
            default: return "register 0 targets";
        endcase
    endfunction

    task automatic make_program(input int kind);
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] chain;
        logic [15:0]            offset;
        int                     count;
        int                     pick;
        chain = `REG_ADDR_W'd1;
        for (int a = 0; a < `IMEM_DEPTH; a++)
            prog[a] = encode_i(6'h08, '0, random_reg(), 16'($urandom)); // r0 no-op fill
        count = 36 + int'($urandom % 9);
        for (int a = 0; a < count; a++)
        begin
            rs     = ($urandom % 2 == 0) ? chain : random_reg();  // dependency chains
            rt     = ($urandom % 3 == 0) ? chain : random_reg();
            rd     = (kind == 2 && $urandom % 2 == 0) ? '0 : random_reg();
            offset = {8'h00, 6'($urandom % 64), 2'b00};
            pick   = (kind == 0) ? int'($urandom % 6) : int'($urandom % 9);
            case (pick)
                0:       prog[a] = encode_r(6'h20, rd, rs, rt);
                1:       prog[a] = encode_r(6'h22, rd, rs, rt);
                2:       prog[a] = encode_r(6'h24, rd, rs, rt);
                3:       prog[a] = encode_r(6'h25, rd, rs, rt);
                4:       prog[a] = encode_r(6'h2A, rd, rs, rt);
                5:       prog[a] = encode_i(6'h08, rd, rs, 16'($urandom));
                6, 7:    prog[a] = encode_i(6'h23, rd, '0, offset);
                default: prog[a] = encode_i(6'h2B, rt, '0, offset);
            endcase
            if (pick < 8)
                chain = rd;   // next use of rd right after a load is common
        end
    endtask

    task automatic load_program();
        @(posedge SYS_clk);
        load       <= 1'b1;
        output_sel <= `SEL_W'd3;
        for (int a = 0; a < `IMEM_DEPTH; a++)
        begin
            imem_we   <= 1'b1;
            imem_addr <= `PC_W'(a);
            imem_data <= prog[a];
            pc_val    <= `PC_W'($urandom);   // pc follows while loading
            @(posedge SYS_clk);
        end
        imem_we <= 1'b0;
        pc_val  <= '0;
        @(posedge SYS_clk);
        load <= 1'b0;
    endtask

    task automatic wait_for_end();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge SYS_clk);
            cycles++;
        end
        while (leds != PC_END && cycles < RUN_TIMEOUT);
        if (leds != PC_END)
        begin
            timed_out = 1'b1;
            $display("timeout: program counter did not reach the last address in %0d cycles",
                     cycles);
        end
        @(posedge SYS_clk);
    endtask

    task automatic read_registers();
        for (int r = 0; r < (1 << `REG_ADDR_W); r++)
        begin
            dbg_reg_addr <= `REG_ADDR_W'(r);
            reg_check    <= 1'b1;
            @(posedge SYS_clk);
        end
        reg_check <= 1'b0;
    endtask

    // steps through every led select while the pc is stopped
    task automatic show_end_selects();
        for (int s = 0; s < (1 << `SEL_W); s++)
        begin
            output_sel <= `SEL_W'(s);
            repeat (2) @(posedge SYS_clk);
        end
        output_sel <= `SEL_W'd3;
        @(posedge SYS_clk);
    endtask

    task automatic run_test(input int num);
        int errs_before;
        errs_before = err_count;
        make_program(kind_of(num));
        load_program();
        wait_for_end();
        if (!timed_out)
        begin
            repeat (8) @(posedge SYS_clk);   // drain the pipe
            read_registers();
            show_end_selects();
        end
        tests_run++;
        if (timed_out || err_count != errs_before)
            tests_failed++;
        $display("test %0d %s: %s, %0d errors", num, test_name(kind_of(num)),
                 (timed_out || err_count != errs_before) ? "failed" : "ok",
                 err_count - errs_before);
    endtask

    initial
    begin
        void'($urandom(9614));
        SYS_reset    = 1'b1;
        load         = 1'b0;
        pc_val       = '0;
        output_sel   = `SEL_W'd3;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        reg_check    = 1'b0;
        timed_out    = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
            run_test(t);
        assert_fails = u_pipe5_core.u_assert.fail_count;
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d, assert fails %0d",
                 tests_run, tests_failed, check_count, err_count, assert_fails);
        if (!timed_out && err_count == 0 && assert_fails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- pipe5_core.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/hazard_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/pipe5_core.sv
sim/pipe5_checker.sv
sim/pipe5_assert.sv
sim/pipe5_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pipe5_tb
FILELIST  = pipe5_core.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
